// ==== filelist.f ====
verilog/core_types_pkg.sv
verilog/mem_bus_pkg.sv
verilog/rob_ifs.sv
verilog/reorder_buffer.sv
verilog/commit_unit.sv
verilog/store_drain.sv
verilog/rob_subsystem.sv
bench/rob_props.sv
bench/rob_subsystem_tb.sv

// ==== Makefile ====
TOP := rob_subsystem_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim
	out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== bench/rob_subsystem_tb.sv ====
`timescale 1ns/100ps

module rob_subsystem_tb import core_types_pkg::*, mem_bus_pkg::*; ();

  typedef struct {
    instr_class_e cls;
    logic [4:0]   rd;
    logic [31:0]  pc, pred, value, next_pc, st_addr, st_data;
    logic [3:0]   st_strb;
    int           slot;
    bit           commits;
  } row_t;

  typedef struct {
    instr_class_e cls;
    logic [4:0]   rd;
    logic [31:0]  value;
    bit           redirect;
    logic [31:0]  redirect_pc;
  } exp_t;

  logic clk = 0, reset = 1;
  logic push_valid, push_ready, commit_valid, redirect_valid;
  instr_class_e push_class;
  logic [4:0] push_rd, commit_rd, arch_raddr;
  logic [31:0] push_pc, push_pred_next, commit_value, redirect_pc, arch_rdata;
  rob_tag_t push_tag, cdb0_tag, cdb1_tag, lookup_tag0, lookup_tag1;
  logic cdb0_valid, cdb1_valid, lookup_valid0, lookup_valid1;
  logic [31:0] cdb0_value, cdb0_next_pc, cdb0_st_addr, cdb0_st_data;
  logic [31:0] cdb1_value, cdb1_next_pc, cdb1_st_addr, cdb1_st_data;
  logic [3:0] cdb0_st_strb, cdb1_st_strb;
  logic [31:0] lookup_value0, lookup_value1;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic [axi_addr_w-1:0] awaddr;
  logic [axi_data_w-1:0] wdata;
  logic [axi_strb_w-1:0] wstrb;
  logic [1:0] bresp;

  row_t tbl [13];
  exp_t sb [$];
  logic [67:0] st_q [$];
  logic [31:0] arch_m [32];
  int tail_m = 0;
  int writes_m = 0;
  logic [31:0] lfsr = 32'hf7ee;
  logic [31:0] cap_addr, cap_data;
  logic [3:0] cap_strb;
  int aw_n = 0, w_n = 0, b_n = 0, aw_wait = 0, w_wait = 0, b_wait = 0;

  rob_subsystem u_rob_subsystem (.*);

  initial forever #5 clk = ~clk;

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  // both lookup ports look at the same tag
  task automatic check_lookups(input logic exp_valid, input logic [31:0] exp_value);
    check_equal("lookup_valid0", 32'(lookup_valid0), 32'(exp_valid));
    check_equal("lookup_valid1", 32'(lookup_valid1), 32'(exp_valid));
    if (exp_valid) begin
      check_equal("lookup_value0", lookup_value0, exp_value);
      check_equal("lookup_value1", lookup_value1, exp_value);
    end
  endtask

  function automatic bit lfsr_bit();
    bit b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic int rand_delay();
    return int'({lfsr_bit(), lfsr_bit()});
  endfunction

  // memory slave model that accepts on the rising edge
  always @(posedge clk) begin
    if (awvalid && awready) begin
      cap_addr = awaddr;
      aw_n++;
      aw_wait = rand_delay();
    end
    if (wvalid && wready) begin
      cap_data = wdata;
      cap_strb = wstrb;
      w_n++;
      w_wait = rand_delay();
    end
    if (bvalid && bready) begin
      if (st_q.size() == 0) report_failure("write response with no store expected");
      check_equal("awaddr", cap_addr, st_q[0][67:36]);
      check_equal("wdata", cap_data, st_q[0][35:4]);
      check_equal("wstrb", 32'(cap_strb), 32'(st_q[0][3:0]));
      void'(st_q.pop_front());
      b_n++;
      b_wait = rand_delay();
    end
  end

  // ready and response delays
  always @(negedge clk) begin
    awready = awvalid && aw_wait == 0;
    if (awvalid && aw_wait > 0) aw_wait--;
    wready = wvalid && w_wait == 0;
    if (wvalid && w_wait > 0) w_wait--;
    if (aw_n > b_n && w_n > b_n) begin
      bvalid = b_wait == 0;
      if (b_wait > 0) b_wait--;
    end else begin
      bvalid = 0;
    end
  end

  // scoreboard of in-order commits
  always @(posedge clk) begin : monitor
    exp_t e;
    if (!reset && commit_valid) begin
      if (sb.size() == 0) report_failure("commit seen with no instruction expected");
      e = sb.pop_front();
      check_equal("commit_rd", 32'(commit_rd), 32'(e.rd));
      check_equal("commit_value", commit_value, e.value);
      check_equal("redirect_valid", 32'(redirect_valid), 32'(e.redirect));
      if (e.redirect) check_equal("redirect_pc", redirect_pc, e.redirect_pc);
      if (e.cls == cls_store) check_equal("bvalid_and_bready", 32'(bvalid && bready), 32'd1);
    end
  end

  task automatic wait_push_ready();
    for (int n = 0; n < 100 && !push_ready; n++) @(negedge clk);
    if (!push_ready) report_failure("timed out waiting for push_ready");
  endtask

  task automatic wait_drain();
    for (int n = 0; n < 300 && (sb.size() != 0 || st_q.size() != 0); n++) @(negedge clk);
    if (sb.size() != 0 || st_q.size() != 0) report_failure("timed out waiting for commits");
  endtask

  task automatic complete(input int tag, input row_t r, input int port);
    @(negedge clk);
    lookup_tag0 = rob_tag_t'(tag);
    lookup_tag1 = rob_tag_t'(tag);
    #1 check_lookups(1'b0, 32'h0);
    @(negedge clk);
    if (port == 0) begin
      cdb0_valid = 1;
      cdb0_tag = rob_tag_t'(tag);
      {cdb0_value, cdb0_next_pc, cdb0_st_addr, cdb0_st_data, cdb0_st_strb} =
        {r.value, r.next_pc, r.st_addr, r.st_data, r.st_strb};
    end else begin
      cdb1_valid = 1;
      cdb1_tag = rob_tag_t'(tag);
      {cdb1_value, cdb1_next_pc, cdb1_st_addr, cdb1_st_data, cdb1_st_strb} =
        {r.value, r.next_pc, r.st_addr, r.st_data, r.st_strb};
    end
    // bypass from the bus
    #1 check_lookups(1'b1, r.value);
    @(negedge clk);
    cdb0_valid = 0;
    cdb1_valid = 0;
    #1 check_lookups(1'b1, r.value);
  endtask

  task automatic run_group(input int first, input int count);
    int tag_of [rob_depth];
    bit flushed;
    row_t r;
    flushed = 0;
    for (int i = 0; i < count; i++) begin
      r = tbl[first + i];
      wait_push_ready();
      push_valid = 1;
      push_class = r.cls;
      push_rd = r.rd;
      push_pc = r.pc;
      push_pred_next = r.pred;
      #1 check_equal("push_tag", 32'(push_tag), 32'(tail_m));
      tag_of[i] = tail_m;
      tail_m = (tail_m + 1) % rob_depth;
      if (r.commits) begin
        sb.push_back(exp_t'{r.cls, r.rd, r.value, r.cls == cls_branch && r.next_pc != r.pred,
                            r.next_pc});
        if (r.cls == cls_store) begin
          st_q.push_back({r.st_addr & ~32'h3, r.st_data, r.st_strb});
          writes_m++;
        end else if (r.rd != 0) begin
          arch_m[r.rd] = r.value;
        end
        if (r.cls == cls_branch && r.next_pc != r.pred) flushed = 1;
      end
      @(negedge clk);
    end
    push_valid = 0;
    if (count == rob_depth) begin
      // offer one more while full
      push_valid = 1;
      #1 check_equal("push_ready", 32'(push_ready), 32'd0);
      @(negedge clk);
      push_valid = 0;
    end
    for (int s = 0; s < count; s++)
      for (int i = 0; i < count; i++)
        if (tbl[first + i].slot == s) complete(tag_of[i], tbl[first + i], s % 2);
    if (count == rob_depth) begin
      check_equal("commit_valid", 32'(commit_valid), 32'd1);
      @(negedge clk);
      #1 check_equal("push_ready", 32'(push_ready), 32'd1);
    end
    wait_drain();
    if (flushed) tail_m = 0;
  endtask

  initial begin
    // full buffer with two stores where tag 0 completes last
    tbl[0]  = '{cls_alu, 5'd1, 32'h100, 32'h104, 32'h1111, 32'h104, 32'h0, 32'h0, 4'h0, 7, 1'b1};
    tbl[1]  = '{cls_branch, 5'd2, 32'h104, 32'h200, 32'h108, 32'h200, 32'h0, 32'h0, 4'h0, 2, 1'b1};
    tbl[2]  = '{cls_alu, 5'd3, 32'h200, 32'h204, 32'h3333, 32'h204, 32'h0, 32'h0, 4'h0, 0, 1'b1};
    tbl[3]  = '{cls_alu, 5'd0, 32'h204, 32'h208, 32'hdead, 32'h208, 32'h0, 32'h0, 4'h0, 5, 1'b1};
    tbl[4]  = '{cls_store, 5'd0, 32'h208, 32'h20c, 32'h0, 32'h20c, 32'h1003, 32'hcafef00d,
                4'hc, 1, 1'b1};
    tbl[5]  = '{cls_alu, 5'd5, 32'h20c, 32'h210, 32'h5555, 32'h210, 32'h0, 32'h0, 4'h0, 6, 1'b1};
    tbl[6]  = '{cls_store, 5'd0, 32'h210, 32'h214, 32'h0, 32'h214, 32'h2006, 32'h12345678,
                4'h3, 3, 1'b1};
    tbl[7]  = '{cls_alu, 5'd7, 32'h214, 32'h218, 32'h7777, 32'h218, 32'h0, 32'h0, 4'h0, 4, 1'b1};
    // mispredicted branch with two younger entries
    tbl[8]  = '{cls_alu, 5'd8, 32'h300, 32'h304, 32'h8888, 32'h304, 32'h0, 32'h0, 4'h0, 2, 1'b1};
    tbl[9]  = '{cls_branch, 5'd9, 32'h304, 32'h308, 32'h308, 32'h400, 32'h0, 32'h0, 4'h0, 3, 1'b1};
    tbl[10] = '{cls_alu, 5'd10, 32'h308, 32'h30c, 32'haaaa, 32'h30c, 32'h0, 32'h0, 4'h0, 0, 1'b0};
    tbl[11] = '{cls_alu, 5'd11, 32'h30c, 32'h310, 32'hbbbb, 32'h310, 32'h0, 32'h0, 4'h0, 1, 1'b0};
    tbl[12] = '{cls_alu, 5'd12, 32'h400, 32'h404, 32'hcccc, 32'h404, 32'h0, 32'h0, 4'h0, 0, 1'b1};
    for (int i = 0; i < 32; i++) arch_m[i] = 32'h0;
    push_valid = 0;
    push_class = cls_alu;
    push_rd = 0;
    push_pc = 0;
    push_pred_next = 0;
    {cdb0_valid, cdb0_tag, cdb0_value, cdb0_next_pc, cdb0_st_addr, cdb0_st_data} = '0;
    {cdb1_valid, cdb1_tag, cdb1_value, cdb1_next_pc, cdb1_st_addr, cdb1_st_data} = '0;
    cdb0_st_strb = 0;
    cdb1_st_strb = 0;
    lookup_tag0 = 0;
    lookup_tag1 = 0;
    arch_raddr = 0;
    awready = 0;
    wready = 0;
    bvalid = 0;
    bresp = resp_okay;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 0;
    #1 check_equal("push_ready", 32'(push_ready), 32'd1);
    check_equal("commit_valid", 32'(commit_valid), 32'd0);
    check_equal("redirect_valid", 32'(redirect_valid), 32'd0);
    check_equal("aw_w_b", 32'({awvalid, wvalid, bready}), 32'd0);
    @(negedge clk);
    run_group(0, 8);
    run_group(8, 4);
    repeat (3) @(negedge clk);
    run_group(12, 1);
    for (int i = 0; i < 32; i++) begin
      @(negedge clk);
      arch_raddr = 5'(i);
      #1 check_equal("arch_rdata", arch_rdata, arch_m[i]);
    end
    // one address, one data and one response per committed store
    check_equal("aw_count", 32'(aw_n), 32'(writes_m));
    check_equal("w_count", 32'(w_n), 32'(writes_m));
    check_equal("b_count", 32'(b_n), 32'(writes_m));
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== bench/rob_props.sv ====
`timescale 1ns/100ps

module rob_props import core_types_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     push_valid,
  input logic     push_ready,
  input rob_tag_t push_tag,
  input logic     flush,
  input logic     commit_valid,
  input logic     awvalid,
  input logic     awready
);

  // tail must not move when a push is offered to a full buffer
  no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    push_valid && !push_ready && !flush |=> $stable(push_tag))
    else $error("push taken while the buffer was full");

  aw_held_until_ready: assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");

  // empty again right after a flush
  flush_empties: assert property (@(posedge clk) disable iff (reset)
    flush |=> push_ready && push_tag == '0 && !commit_valid)
    else $error("buffer not empty after flush");

endmodule

bind rob_subsystem rob_props u_props (.*);

// ==== verilog/rob_subsystem.sv ====
`timescale 1ns/100ps

module rob_subsystem import core_types_pkg::*, mem_bus_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  // issue
  input  logic                  push_valid,
  output logic                  push_ready,
  input  instr_class_e          push_class,
  input  logic [4:0]            push_rd,
  input  logic [31:0]           push_pc,
  input  logic [31:0]           push_pred_next,
  output rob_tag_t              push_tag,
  // common data bus, port 0
  input  logic                  cdb0_valid,
  input  rob_tag_t              cdb0_tag,
  input  logic [31:0]           cdb0_value,
  input  logic [31:0]           cdb0_next_pc,
  input  logic [31:0]           cdb0_st_addr,
  input  logic [31:0]           cdb0_st_data,
  input  logic [3:0]            cdb0_st_strb,
  // common data bus, port 1
  input  logic                  cdb1_valid,
  input  rob_tag_t              cdb1_tag,
  input  logic [31:0]           cdb1_value,
  input  logic [31:0]           cdb1_next_pc,
  input  logic [31:0]           cdb1_st_addr,
  input  logic [31:0]           cdb1_st_data,
  input  logic [3:0]            cdb1_st_strb,
  // operand lookup
  input  rob_tag_t              lookup_tag0,
  input  rob_tag_t              lookup_tag1,
  output logic                  lookup_valid0,
  output logic                  lookup_valid1,
  output logic [31:0]           lookup_value0,
  output logic [31:0]           lookup_value1,
  // retirement
  output logic                  commit_valid,
  output logic [4:0]            commit_rd,
  output logic [31:0]           commit_value,
  output logic                  redirect_valid,
  output logic [31:0]           redirect_pc,
  input  logic [4:0]            arch_raddr,
  output logic [31:0]           arch_rdata,
  // AXI4-Lite write channels
  output logic                  awvalid,
  input  logic                  awready,
  output logic [axi_addr_w-1:0] awaddr,
  output logic                  wvalid,
  input  logic                  wready,
  output logic [axi_data_w-1:0] wdata,
  output logic [axi_strb_w-1:0] wstrb,
  input  logic                  bvalid,
  output logic                  bready,
  input  logic [1:0]            bresp
);

  cdb_if       cdb_bus [cdb_ports] ();
  rob_head_if  head_bus ();
  store_req_if store_bus ();
  logic        flush;

  assign cdb_bus[0].valid   = cdb0_valid;
  assign cdb_bus[0].tag     = cdb0_tag;
  assign cdb_bus[0].value   = cdb0_value;
  assign cdb_bus[0].next_pc = cdb0_next_pc;
  assign cdb_bus[0].st_addr = cdb0_st_addr;
  assign cdb_bus[0].st_data = cdb0_st_data;
  assign cdb_bus[0].st_strb = cdb0_st_strb;

  assign cdb_bus[1].valid   = cdb1_valid;
  assign cdb_bus[1].tag     = cdb1_tag;
  assign cdb_bus[1].value   = cdb1_value;
  assign cdb_bus[1].next_pc = cdb1_next_pc;
  assign cdb_bus[1].st_addr = cdb1_st_addr;
  assign cdb_bus[1].st_data = cdb1_st_data;
  assign cdb_bus[1].st_strb = cdb1_st_strb;

  reorder_buffer u_rob (
    .clk            (clk),
    .reset          (reset),
    .push_valid     (push_valid),
    .push_ready     (push_ready),
    .push_class     (push_class),
    .push_rd        (push_rd),
    .push_pc        (push_pc),
    .push_pred_next (push_pred_next),
    .push_tag       (push_tag),
    .cdb            (cdb_bus),
    .lookup_tag0    (lookup_tag0),
    .lookup_tag1    (lookup_tag1),
    .lookup_valid0  (lookup_valid0),
    .lookup_valid1  (lookup_valid1),
    .lookup_value0  (lookup_value0),
    .lookup_value1  (lookup_value1),
    .head           (head_bus),
    .flush          (flush)
  );

  commit_unit u_commit (
    .clk            (clk),
    .reset          (reset),
    .head           (head_bus),
    .store          (store_bus),
    .flush          (flush),
    .commit_valid   (commit_valid),
    .commit_rd      (commit_rd),
    .commit_value   (commit_value),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .arch_raddr     (arch_raddr),
    .arch_rdata     (arch_rdata)
  );

  store_drain u_store (
    .clk     (clk),
    .reset   (reset),
    .req     (store_bus),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp)
  );

endmodule

// ==== verilog/store_drain.sv ====
`timescale 1ns/100ps

module store_drain import mem_bus_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  store_req_if.slave            req,
  // write address
  output logic                  awvalid,
  input  logic                  awready,
  output logic [axi_addr_w-1:0] awaddr,
  // write data
  output logic                  wvalid,
  input  logic                  wready,
  output logic [axi_data_w-1:0] wdata,
  output logic [axi_strb_w-1:0] wstrb,
  // write response, code not inspected without an exception path
  input  logic                  bvalid,
  output logic                  bready,
  input  logic [1:0]            bresp
);

  typedef enum logic [1:0] {idle, addr_data, resp} state_e;

  state_e state_q;
  logic aw_done_q;
  logic w_done_q;
  logic aw_acc;
  logic w_acc;

  // request payload is held by the buffer head until done
  assign awaddr = {req.addr[axi_addr_w-1:2], 2'b00};
  assign wdata  = req.data;
  assign wstrb  = req.strb;

  assign awvalid  = state_q == addr_data && !aw_done_q;
  assign wvalid   = state_q == addr_data && !w_done_q;
  assign bready   = state_q == resp;
  assign req.done = bvalid && bready;

  assign aw_acc = aw_done_q || (awvalid && awready);
  assign w_acc  = w_done_q || (wvalid && wready);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q   <= idle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        idle: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (req.req_valid) begin
            state_q <= addr_data;
          end
        end
        addr_data: begin
          aw_done_q <= aw_acc;
          w_done_q  <= w_acc;
          // both channels accepted, possibly in different cycles
          if (aw_acc && w_acc) begin
            state_q <= resp;
          end
        end
        resp: begin
          if (req.done) begin
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

endmodule

// ==== verilog/commit_unit.sv ====
`timescale 1ns/100ps

module commit_unit import core_types_pkg::*, mem_bus_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  rob_head_if.commit   head,
  store_req_if.master  store,
  output logic         flush,
  // retirement observation
  output logic         commit_valid,
  output logic [4:0]   commit_rd,
  output logic [31:0]  commit_value,
  // front end redirect
  output logic         redirect_valid,
  output logic [31:0]  redirect_pc,
  // architectural read port
  input  logic [4:0]   arch_raddr,
  output logic [31:0]  arch_rdata
);

  logic [31:0] regs [32];
  logic head_done;
  logic is_store;
  logic is_branch;
  logic mispredict;

  assign head_done = head.head_valid && head.head_ready;
  assign is_store  = head.entry.cls == cls_store;
  assign is_branch = head.entry.cls == cls_branch;

  // a store hands off to the write path and waits for its response
  assign store.req_valid = head_done && is_store;
  assign store.addr      = head.entry.st_addr[axi_addr_w-1:0];
  assign store.data      = head.entry.st_data[axi_data_w-1:0];
  assign store.strb      = head.entry.st_strb[axi_strb_w-1:0];

  assign commit_valid = head_done && (!is_store || store.done);
  assign head.pop     = commit_valid;
  assign commit_rd    = head.entry.rd;
  assign commit_value = head.entry.value;

  // wrong path after a branch whose target was mispredicted
  assign mispredict = commit_valid && is_branch &&
                      (head.entry.next_pc != head.entry.pred_next);

  assign flush          = mispredict;
  assign redirect_valid = mispredict;
  assign redirect_pc    = head.entry.next_pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else if (commit_valid && !is_store && head.entry.rd != 5'd0) begin
      regs[head.entry.rd] <= head.entry.value;
    end
  end

  // x0 hardwired
  assign arch_rdata = (arch_raddr == 5'd0) ? '0 : regs[arch_raddr];

endmodule

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/100ps

module reorder_buffer import core_types_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  // issue side
  input  logic          push_valid,
  output logic          push_ready,
  input  instr_class_e  push_class,
  input  logic [4:0]    push_rd,
  input  logic [31:0]   push_pc,
  input  logic [31:0]   push_pred_next,
  output rob_tag_t      push_tag,
  // completion
  cdb_if.snk            cdb [cdb_ports],
  // operand lookup
  input  rob_tag_t      lookup_tag0,
  input  rob_tag_t      lookup_tag1,
  output logic          lookup_valid0,
  output logic          lookup_valid1,
  output logic [31:0]   lookup_value0,
  output logic [31:0]   lookup_value1,
  // retirement
  rob_head_if.rob       head,
  input  logic          flush
);

  rob_entry_t entries [rob_depth];
  logic [rob_depth-1:0] valid_q;
  logic [rob_depth-1:0] ready_q;
  rob_tag_t head_q;
  rob_tag_t tail_q;
  logic push_fire;

  // bus ports flattened to plain arrays
  logic        cdb_valid   [cdb_ports];
  rob_tag_t    cdb_tag     [cdb_ports];
  logic [31:0] cdb_value   [cdb_ports];
  logic [31:0] cdb_next_pc [cdb_ports];
  logic [31:0] cdb_st_addr [cdb_ports];
  logic [31:0] cdb_st_data [cdb_ports];
  logic [3:0]  cdb_st_strb [cdb_ports];

  rob_tag_t    lk_tag   [2];
  logic        lk_valid [2];
  logic [31:0] lk_value [2];

  for (genvar p = 0; p < cdb_ports; p++) begin : g_cdb
    assign cdb_valid[p]   = cdb[p].valid;
    assign cdb_tag[p]     = cdb[p].tag;
    assign cdb_value[p]   = cdb[p].value;
    assign cdb_next_pc[p] = cdb[p].next_pc;
    assign cdb_st_addr[p] = cdb[p].st_addr;
    assign cdb_st_data[p] = cdb[p].st_data;
    assign cdb_st_strb[p] = cdb[p].st_strb;
  end

  // full when the tail slot is still occupied
  assign push_ready = !valid_q[tail_q];
  assign push_tag   = tail_q;
  assign push_fire  = push_valid && push_ready;

  assign head.head_valid = valid_q[head_q];
  assign head.head_ready = ready_q[head_q];
  assign head.entry      = entries[head_q];

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid_q <= '0;
      ready_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
    end else begin
      if (push_fire) begin
        valid_q[tail_q] <= 1'b1;
        ready_q[tail_q] <= 1'b0;
        tail_q          <= tail_q + rob_tag_t'(1);
      end
      for (int p = 0; p < cdb_ports; p++) begin
        if (cdb_valid[p]) begin
          ready_q[cdb_tag[p]] <= 1'b1;
        end
      end
      if (head.pop) begin
        valid_q[head_q] <= 1'b0;
        ready_q[head_q] <= 1'b0;
        head_q          <= head_q + rob_tag_t'(1);
      end
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (push_fire) begin
      entries[tail_q].cls       <= push_class;
      entries[tail_q].rd        <= push_rd;
      entries[tail_q].pc        <= push_pc;
      entries[tail_q].pred_next <= push_pred_next;
    end
    for (int p = 0; p < cdb_ports; p++) begin
      if (cdb_valid[p]) begin
        entries[cdb_tag[p]].value   <= cdb_value[p];
        entries[cdb_tag[p]].next_pc <= cdb_next_pc[p];
        entries[cdb_tag[p]].st_addr <= cdb_st_addr[p];
        entries[cdb_tag[p]].st_data <= cdb_st_data[p];
        entries[cdb_tag[p]].st_strb <= cdb_st_strb[p];
      end
    end
  end

  assign lk_tag[0] = lookup_tag0;
  assign lk_tag[1] = lookup_tag1;

  // stored value first, a result on the bus this cycle overrides it
  always_comb begin
    for (int l = 0; l < 2; l++) begin
      lk_valid[l] = 1'b0;
      lk_value[l] = '0;
      if (valid_q[lk_tag[l]]) begin
        if (ready_q[lk_tag[l]]) begin
          lk_valid[l] = 1'b1;
          lk_value[l] = entries[lk_tag[l]].value;
        end
        for (int p = 0; p < cdb_ports; p++) begin
          if (cdb_valid[p] && cdb_tag[p] == lk_tag[l]) begin
            lk_valid[l] = 1'b1;
            lk_value[l] = cdb_value[p];
          end
        end
      end
    end
  end

  assign lookup_valid0 = lk_valid[0];
  assign lookup_valid1 = lk_valid[1];
  assign lookup_value0 = lk_value[0];
  assign lookup_value1 = lk_value[1];

endmodule

// ==== verilog/rob_ifs.sv ====
`timescale 1ns/100ps

// one result port of the common data bus
interface cdb_if import core_types_pkg::*; ();
  logic        valid;
  rob_tag_t    tag;
  logic [31:0] value;
  logic [31:0] next_pc;
  logic [31:0] st_addr;
  logic [31:0] st_data;
  logic [3:0]  st_strb;

  modport src (output valid, tag, value, next_pc, st_addr, st_data, st_strb);
  modport snk (input valid, tag, value, next_pc, st_addr, st_data, st_strb);
endinterface

// oldest entry, seen by the commit side
interface rob_head_if import core_types_pkg::*; ();
  logic       head_valid;
  logic       head_ready;
  rob_entry_t entry;
  logic       pop;

  modport rob (output head_valid, head_ready, entry, input pop);
  modport commit (input head_valid, head_ready, entry, output pop);
endinterface

// committed store waiting for its memory write
interface store_req_if import mem_bus_pkg::*; ();
  logic                  req_valid;
  logic [axi_addr_w-1:0] addr;
  logic [axi_data_w-1:0] data;
  logic [axi_strb_w-1:0] strb;
  logic                  done;

  modport master (output req_valid, addr, data, strb, input done);
  modport slave (input req_valid, addr, data, strb, output done);
endinterface

// ==== verilog/mem_bus_pkg.sv ====
package mem_bus_pkg;

  // AXI4-Lite geometry of the data side
  localparam int axi_addr_w = 32;
  localparam int axi_data_w = 32;
  localparam int axi_strb_w = axi_data_w / 8;

  // write response codes
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

// ==== verilog/core_types_pkg.sv ====
package core_types_pkg;

  // buffer geometry
  localparam int rob_depth = 8;
  localparam int tag_w     = 3;
  localparam int cdb_ports = 2;

  // a tag is simply the slot index in the buffer
  typedef logic [tag_w-1:0] rob_tag_t;

  // only the classes that retire differently
  typedef enum logic [1:0] {
    cls_alu    = 2'd0,
    cls_branch = 2'd1,
    cls_store  = 2'd2
  } instr_class_e;

  typedef struct packed {
    // written at push
    instr_class_e cls;
    logic [4:0]   rd;
    logic [31:0]  pc;
    logic [31:0]  pred_next;
    // written at completion
    logic [31:0]  value;
    logic [31:0]  next_pc;
    // store payload, don't care for other classes
    logic [31:0]  st_addr;
    logic [31:0]  st_data;
    logic [3:0]   st_strb;
  } rob_entry_t;

endpackage
